//--- include/aexm_consts.svh
`ifndef AEXM_CONSTS_SVH
`define AEXM_CONSTS_SVH

// First fetch address out of reset
`define AEXM_RESET_VECTOR 32'h0000_0000

// Data and address width
`define AEXM_WORD_W 32

// General purpose registers, r0 reads as zero
`define AEXM_REG_COUNT 32

`endif

//--- hdl/aexmIsaPkg.sv
`include "aexm_consts.svh"

package aexmIsaPkg;

  // Major opcode, instruction bits 31:26
  typedef enum logic [5:0] {
    OP_ADD  = 6'b000000,
    OP_ADDI = 6'b001000,
    OP_OR   = 6'b100000,
    OP_AND  = 6'b100001,
    OP_XOR  = 6'b100010,
    OP_BRI  = 6'b101110,  // Unconditional, rA field holds link/absolute flags
    OP_BEQI = 6'b101111,  // Condition code sits in the rD field
    OP_LWI  = 6'b111010,
    OP_SWI  = 6'b111110
  } opcode_t;

  typedef enum logic [1:0] {
    ALU_ADD,
    ALU_AND,
    ALU_OR,
    ALU_XOR
  } aluOp_t;

  // One instruction after decode, as held in the instruction register
  typedef struct packed {
    logic                    valid;
    opcode_t                 opcode;
    logic [4:0]              rd;
    logic [4:0]              ra;
    logic [4:0]              rb;        // Second read index, rD for stores
    logic [`AEXM_WORD_W-1:0] imm;       // Sign-extended imm16
    aluOp_t                  aluOp;
    logic                    useImm;
    logic                    isLoad;
    logic                    isStore;
    logic                    isBranch;
    logic [`AEXM_WORD_W-1:0] pc;
  } decodedInstr_t;

endpackage

//--- hdl/aexmBusPkg.sv
`include "aexm_consts.svh"

package aexmBusPkg;

  // Instruction cache request, presented one cycle ahead of the data
  typedef struct packed {
    logic [`AEXM_WORD_W-1:0] precycleAddr;
    logic                    enable;
  } icacheReq_t;

  // Data cache request
  // A write happens in the cycle where both enable and we are high
  typedef struct packed {
    logic [`AEXM_WORD_W-1:0] precycleAddr;
    logic [`AEXM_WORD_W-1:0] wrData;
    logic                    we;
    logic                    enable;
  } dcacheReq_t;

endpackage

//--- hdl/aexmEnable.sv
module aexmEnable (
  input  logic sys_clk_i,
  input  logic reset_i,
  input  logic icacheBusy_i,
  input  logic dcacheBusy_i,
  input  logic loadIssue_i,
  output logic cpuEnable_o,
  output logic loadWait_o
);

  typedef enum logic {
    RUN,
    LOAD_WAIT
  } state_t;

  state_t state;
  state_t stateNext;

  always_comb begin
    stateNext = state;
    case (state)
      RUN: begin
        if (loadIssue_i && cpuEnable_o) begin  // Load accepted by the dcache
          stateNext = LOAD_WAIT;
        end
      end
      LOAD_WAIT: begin
        if (!dcacheBusy_i) begin  // Load data is on the bus this cycle
          stateNext = RUN;
        end
      end
      default: stateNext = RUN;
    endcase
  end

  always_ff @(posedge sys_clk_i) begin
    if (reset_i) begin
      state <= RUN;
    end else begin
      state <= stateNext;
    end
  end

  // Any busy cache or a pending load freezes every stage
  assign cpuEnable_o = (state == RUN) && !icacheBusy_i && !dcacheBusy_i;
  assign loadWait_o  = (state == LOAD_WAIT);

  assert property (@(posedge sys_clk_i) disable iff (reset_i)
    (state == LOAD_WAIT) && dcacheBusy_i |=> state == LOAD_WAIT)
    else $error("Left LOAD_WAIT before the load data returned");

endmodule

//--- hdl/aexmFetch.sv
`include "aexm_consts.svh"

module aexmFetch import aexmBusPkg::*; (
  input  logic                    sys_clk_i,
  input  logic                    reset_i,
  input  logic                    cpuEnable_i,
  input  logic                    redirect_i,
  input  logic [`AEXM_WORD_W-1:0] redirectPc_i,
  output icacheReq_t              icacheReq_o,
  output logic [`AEXM_WORD_W-1:0] fetchPc_o
);

  logic [`AEXM_WORD_W-1:0] pc;
  logic [`AEXM_WORD_W-1:0] pcNext;

  // Taken branch from execute wins over the sequential step
  assign pcNext = redirect_i ? redirectPc_i : pc + 'd4;

  always_ff @(posedge sys_clk_i) begin
    if (reset_i) begin
      pc <= `AEXM_RESET_VECTOR;
    end else if (cpuEnable_i) begin
      pc <= pcNext;
    end
  end

  // Address of the word the icache returns next
  always_ff @(posedge sys_clk_i) begin
    if (cpuEnable_i) begin
      fetchPc_o <= pc;
    end
  end

  // One request per enabled cycle, none while frozen
  always_comb begin
    icacheReq_o.precycleAddr = pc;
    icacheReq_o.enable       = cpuEnable_i;
  end

  // Redirect targets come from execute, so check them here
  assert property (@(posedge sys_clk_i) disable iff (reset_i)
    icacheReq_o.enable |-> icacheReq_o.precycleAddr[1:0] == 2'b00)
    else $error("Misaligned fetch address %h", icacheReq_o.precycleAddr);

endmodule

//--- hdl/aexmIbuf.sv
`include "aexm_consts.svh"

module aexmIbuf import aexmIsaPkg::*; (
  input  logic                    sys_clk_i,
  input  logic                    reset_i,
  input  logic                    cpuEnable_i,
  input  logic                    redirect_i,
  input  logic [`AEXM_WORD_W-1:0] icacheData_i,
  input  logic [`AEXM_WORD_W-1:0] fetchPc_i,
  output decodedInstr_t           instr_o
);

  decodedInstr_t dec;
  decodedInstr_t payload;
  logic          instrValid;
  logic          squash;  // Second word behind a taken branch

  always_comb begin
    dec        = '0;
    dec.valid  = 1'b1;
    dec.opcode = opcode_t'(icacheData_i[31:26]);
    dec.rd     = icacheData_i[25:21];
    dec.ra     = icacheData_i[20:16];
    dec.rb     = icacheData_i[15:11];
    dec.imm    = {{16{icacheData_i[15]}}, icacheData_i[15:0]};
    dec.pc     = fetchPc_i;
    case (dec.opcode)
      OP_ADD: dec.aluOp = ALU_ADD;
      OP_AND: dec.aluOp = ALU_AND;
      OP_OR:  dec.aluOp = ALU_OR;
      OP_XOR: dec.aluOp = ALU_XOR;
      OP_ADDI: begin
        dec.aluOp  = ALU_ADD;
        dec.useImm = 1'b1;
      end
      OP_LWI: begin
        dec.aluOp  = ALU_ADD;  // Address is rA + imm
        dec.useImm = 1'b1;
        dec.isLoad = 1'b1;
      end
      OP_SWI: begin
        dec.aluOp   = ALU_ADD;
        dec.useImm  = 1'b1;
        dec.isStore = 1'b1;
        dec.rb      = icacheData_i[25:21];  // Store data comes from rD
      end
      OP_BRI, OP_BEQI: dec.isBranch = 1'b1;
      default: dec.valid = 1'b0;  // Unknown opcode runs as a no-op
    endcase
  end

  // Reset leaves squash set so the first word latched, fetched before any request, is dropped
  always_ff @(posedge sys_clk_i) begin
    if (reset_i) begin
      instrValid <= 1'b0;
      squash     <= 1'b1;
    end else if (cpuEnable_i) begin
      instrValid <= dec.valid && !squash && !redirect_i;
      squash     <= redirect_i;
    end
  end

  always_ff @(posedge sys_clk_i) begin
    if (cpuEnable_i) begin
      payload <= dec;
    end
  end

  always_comb begin
    instr_o       = payload;
    instr_o.valid = instrValid;
  end

endmodule

//--- hdl/aexmRegf.sv
`include "aexm_consts.svh"

module aexmRegf (
  input  logic                    sys_clk_i,
  input  logic                    reset_i,
  input  logic [4:0]              readA_i,
  input  logic [4:0]              readB_i,
  input  logic [4:0]              writeIdx_i,
  input  logic                    writeEn_i,
  input  logic [`AEXM_WORD_W-1:0] writeData_i,
  output logic [`AEXM_WORD_W-1:0] dataA_o,
  output logic [`AEXM_WORD_W-1:0] dataB_o
);

  logic [`AEXM_WORD_W-1:0] regs [`AEXM_REG_COUNT];

  always_ff @(posedge sys_clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < `AEXM_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (writeEn_i && (writeIdx_i != 5'd0)) begin  // r0 is hardwired
      regs[writeIdx_i] <= writeData_i;
    end
  end

  // Asynchronous reads, a write shows up to the very next instruction
  assign dataA_o = regs[readA_i];
  assign dataB_o = regs[readB_i];

  assert property (@(posedge sys_clk_i) disable iff (reset_i)
    (readA_i == 5'd0) |-> (dataA_o == '0))
    else $error("r0 read nonzero on port A: %h", dataA_o);

  assert property (@(posedge sys_clk_i) disable iff (reset_i)
    (readB_i == 5'd0) |-> (dataB_o == '0))
    else $error("r0 read nonzero on port B: %h", dataB_o);

endmodule

//--- hdl/aexmExec.sv
`include "aexm_consts.svh"

module aexmExec import aexmIsaPkg::*, aexmBusPkg::*; (
  input  logic                    sys_clk_i,
  input  logic                    reset_i,
  input  logic                    cpuEnable_i,
  input  logic                    loadWait_i,
  input  decodedInstr_t           instr_i,
  input  logic [`AEXM_WORD_W-1:0] dataA_i,
  input  logic [`AEXM_WORD_W-1:0] dataB_i,
  input  logic [`AEXM_WORD_W-1:0] dcacheData_i,
  output logic [4:0]              regWriteIdx_o,
  output logic                    regWriteEn_o,
  output logic [`AEXM_WORD_W-1:0] regWriteData_o,
  output logic                    redirect_o,
  output logic [`AEXM_WORD_W-1:0] redirectPc_o,
  output logic                    loadIssue_o,
  output dcacheReq_t              dcacheReq_o
);

  logic [`AEXM_WORD_W-1:0] opB;
  logic [`AEXM_WORD_W-1:0] aluResult;
  logic                    aluWrite;
  logic                    memOp;
  logic [4:0]              loadRd;

  assign opB = instr_i.useImm ? instr_i.imm : dataB_i;

  // Also forms the load/store address, rA + imm
  always_comb begin
    case (instr_i.aluOp)
      ALU_ADD: aluResult = dataA_i + opB;
      ALU_AND: aluResult = dataA_i & opB;
      ALU_OR:  aluResult = dataA_i | opB;
      ALU_XOR: aluResult = dataA_i ^ opB;
      default: aluResult = dataA_i + opB;
    endcase
  end

  // BEQI tests rA against zero, BRI always goes
  assign redirect_o   = instr_i.valid && instr_i.isBranch &&
                        ((instr_i.opcode == OP_BRI) || (dataA_i == '0));
  assign redirectPc_o = instr_i.pc + instr_i.imm;

  assign aluWrite    = instr_i.valid && !instr_i.isLoad && !instr_i.isStore &&
                       !instr_i.isBranch;
  assign memOp       = instr_i.valid && (instr_i.isLoad || instr_i.isStore);
  assign loadIssue_o = instr_i.valid && instr_i.isLoad;

  // Destination of the load in flight
  always_ff @(posedge sys_clk_i) begin
    if (cpuEnable_i && loadIssue_o) begin
      loadRd <= instr_i.rd;
    end
  end

  // Every wait cycle writes, the last one carries the valid word
  assign regWriteEn_o   = (aluWrite && cpuEnable_i) || loadWait_i;
  assign regWriteIdx_o  = loadWait_i ? loadRd : instr_i.rd;
  assign regWriteData_o = loadWait_i ? dcacheData_i : aluResult;

  always_comb begin
    dcacheReq_o.precycleAddr = aluResult;
    dcacheReq_o.wrData       = dataB_i;  // rD via the second read port
    dcacheReq_o.we           = instr_i.valid && instr_i.isStore && cpuEnable_i;
    dcacheReq_o.enable       = memOp && cpuEnable_i;
  end

  assert property (@(posedge sys_clk_i) disable iff (reset_i)
    dcacheReq_o.we |-> dcacheReq_o.enable)
    else $error("dcache write without enable");

  assert property (@(posedge sys_clk_i) disable iff (reset_i)
    dcacheReq_o.enable |-> dcacheReq_o.precycleAddr[1:0] == 2'b00)
    else $error("Misaligned data address %h", dcacheReq_o.precycleAddr);

  // The enable block has to hold the pipe for the load data
  assert property (@(posedge sys_clk_i) disable iff (reset_i)
    loadIssue_o && cpuEnable_i |=> loadWait_i)
    else $error("Load issued without a wait cycle");

endmodule

//--- hdl/aexmCore.sv
`include "aexm_consts.svh"

module aexmCore import aexmIsaPkg::*, aexmBusPkg::*; (
  input  logic                    sys_clk_i,
  input  logic                    reset_i,
  input  logic [`AEXM_WORD_W-1:0] icacheData_i,
  input  logic                    icacheBusy_i,
  input  logic [`AEXM_WORD_W-1:0] dcacheData_i,
  input  logic                    dcacheBusy_i,
  output icacheReq_t              icacheReq_o,
  output dcacheReq_t              dcacheReq_o
);

  logic                    cpuEnable;
  logic                    loadWait;
  logic                    loadIssue;
  logic                    redirect;
  logic [`AEXM_WORD_W-1:0] redirectPc;
  logic [`AEXM_WORD_W-1:0] fetchPc;
  decodedInstr_t           instr;
  logic [`AEXM_WORD_W-1:0] dataA;
  logic [`AEXM_WORD_W-1:0] dataB;
  logic [4:0]              regWriteIdx;
  logic                    regWriteEn;
  logic [`AEXM_WORD_W-1:0] regWriteData;

  aexmEnable aexmEnable_inst (
    .sys_clk_i   (sys_clk_i),
    .reset_i     (reset_i),
    .icacheBusy_i(icacheBusy_i),
    .dcacheBusy_i(dcacheBusy_i),
    .loadIssue_i (loadIssue),
    .cpuEnable_o (cpuEnable),
    .loadWait_o  (loadWait)
  );

  aexmFetch aexmFetch_inst (
    .sys_clk_i   (sys_clk_i),
    .reset_i     (reset_i),
    .cpuEnable_i (cpuEnable),
    .redirect_i  (redirect),
    .redirectPc_i(redirectPc),
    .icacheReq_o (icacheReq_o),
    .fetchPc_o   (fetchPc)
  );

  aexmIbuf aexmIbuf_inst (
    .sys_clk_i   (sys_clk_i),
    .reset_i     (reset_i),
    .cpuEnable_i (cpuEnable),
    .redirect_i  (redirect),
    .icacheData_i(icacheData_i),
    .fetchPc_i   (fetchPc),
    .instr_o     (instr)
  );

  // Read indices come straight from the instruction register
  aexmRegf aexmRegf_inst (
    .sys_clk_i  (sys_clk_i),
    .reset_i    (reset_i),
    .readA_i    (instr.ra),
    .readB_i    (instr.rb),
    .writeIdx_i (regWriteIdx),
    .writeEn_i  (regWriteEn),
    .writeData_i(regWriteData),
    .dataA_o    (dataA),
    .dataB_o    (dataB)
  );

  aexmExec aexmExec_inst (
    .sys_clk_i     (sys_clk_i),
    .reset_i       (reset_i),
    .cpuEnable_i   (cpuEnable),
    .loadWait_i    (loadWait),
    .instr_i       (instr),
    .dataA_i       (dataA),
    .dataB_i       (dataB),
    .dcacheData_i  (dcacheData_i),
    .regWriteIdx_o (regWriteIdx),
    .regWriteEn_o  (regWriteEn),
    .regWriteData_o(regWriteData),
    .redirect_o    (redirect),
    .redirectPc_o  (redirectPc),
    .loadIssue_o   (loadIssue),
    .dcacheReq_o   (dcacheReq_o)
  );

endmodule

//--- test/aexmCacheModel.sv
`include "aexm_consts.svh"

module aexmCacheModel import aexmBusPkg::*; (
  input  logic                    sys_clk_i,
  input  logic                    reset_i,
  input  icacheReq_t              icacheReq_i,
  input  dcacheReq_t              dcacheReq_i,
  output logic [`AEXM_WORD_W-1:0] icacheData_o,
  output logic                    icacheBusy_o,
  output logic [`AEXM_WORD_W-1:0] dcacheData_o,
  output logic                    dcacheBusy_o
);

  timeunit 1ns;
  timeprecision 1ps;

  logic [`AEXM_WORD_W-1:0] rom [64];  // Loaded by the testbench
  logic [`AEXM_WORD_W-1:0] ram [256];
  logic                    armed;     // Keeps busy low in the first cycle out of reset

  // Busy draws come from this process, so the seed applies to them
  initial begin
    void'($urandom(21));
    for (int i = 0; i < 256; i++) begin
      ram[i] = {8'hC3, i[7:0], ~i[7:0], i[7:0] ^ 8'h5A};
    end
    icacheData_o = '0;
    dcacheData_o = '0;
    icacheBusy_o = 1'b0;
    dcacheBusy_o = 1'b0;
    armed        = 1'b0;
    forever begin
      @(posedge sys_clk_i);
      armed <= !reset_i;
      if (reset_i || !armed) begin
        icacheBusy_o <= 1'b0;
        dcacheBusy_o <= 1'b0;
      end else begin
        icacheBusy_o <= ($urandom % 4) == 0;  // About one cycle in four
        dcacheBusy_o <= ($urandom % 4) == 0;
      end
      if (icacheReq_i.enable) begin
        icacheData_o <= rom[icacheReq_i.precycleAddr[7:2]];
      end
      if (dcacheReq_i.enable) begin
        if (dcacheReq_i.we) begin
          ram[dcacheReq_i.precycleAddr[9:2]] <= dcacheReq_i.wrData;
        end else begin
          dcacheData_o <= ram[dcacheReq_i.precycleAddr[9:2]];
        end
      end
    end
  end

endmodule

//--- test/aexmCoreTb.sv
`include "aexm_consts.svh"

module aexmCoreTb import aexmIsaPkg::*, aexmBusPkg::*;;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int PROG_LEN = 27;
  localparam int WATCHDOG_NS = PROG_LEN * 40 * 2 * 8;  // Doubled for busy cycles

  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] data;
  } storeRec_t;

  logic                    sys_clk;
  logic                    reset_i = 1'b1;
  logic [`AEXM_WORD_W-1:0] icacheData;
  logic                    icacheBusy;
  logic [`AEXM_WORD_W-1:0] dcacheData;
  logic                    dcacheBusy;
  icacheReq_t              icacheReq;
  dcacheReq_t              dcacheReq;

  logic [31:0] prog [64];
  storeRec_t   storeQ[$];
  storeRec_t   expHead;
  logic        expValid = 1'b0;

  aexmCore aexmCore_inst (
    .sys_clk_i   (sys_clk),
    .reset_i     (reset_i),
    .icacheData_i(icacheData),
    .icacheBusy_i(icacheBusy),
    .dcacheData_i(dcacheData),
    .dcacheBusy_i(dcacheBusy),
    .icacheReq_o (icacheReq),
    .dcacheReq_o (dcacheReq)
  );

  aexmCacheModel cacheModel_inst (
    .sys_clk_i   (sys_clk),
    .reset_i     (reset_i),
    .icacheReq_i (icacheReq),
    .dcacheReq_i (dcacheReq),
    .icacheData_o(icacheData),
    .icacheBusy_o(icacheBusy),
    .dcacheData_o(dcacheData),
    .dcacheBusy_o(dcacheBusy)
  );

  task automatic stopOnError(input string msg);
    $display("%s", msg);
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  function automatic logic [31:0] encReg(input logic [5:0] op, input int rd, ra, rb);
    return {op, rd[4:0], ra[4:0], rb[4:0], 11'd0};
  endfunction

  function automatic logic [31:0] encImm(input logic [5:0] op, input int rd, ra, imm);
    return {op, rd[4:0], ra[4:0], imm[15:0]};
  endfunction

  // Initial data memory contents, a function of the word index
  function automatic logic [31:0] memFill(input int i);
    return {8'hC3, i[7:0], ~i[7:0], i[7:0] ^ 8'h5A};
  endfunction

  task automatic buildProgram();
    for (int i = 0; i < 64; i++) begin
      prog[i] = 32'hFC00_0000;  // Undefined opcode, a no-op
    end
    prog[0]  = encImm(6'b001000, 1, 0, 6);
    prog[1]  = encImm(6'b001000, 2, 0, -3);  // Negative immediate
    prog[2]  = encReg(6'b000000, 3, 1, 2);
    prog[3]  = encImm(6'b111110, 3, 0, 'h100);
    prog[4]  = encReg(6'b100001, 4, 1, 2);
    prog[5]  = encReg(6'b100000, 5, 1, 2);
    prog[6]  = encReg(6'b100010, 6, 1, 2);
    prog[7]  = encImm(6'b111110, 4, 0, 'h104);
    prog[8]  = encImm(6'b111110, 5, 0, 'h108);
    prog[9]  = encImm(6'b111110, 6, 0, 'h10C);
    prog[10] = encImm(6'b111010, 7, 0, 'h200);
    prog[11] = encImm(6'b001000, 8, 7, 1);  // Uses the load result at once
    prog[12] = encImm(6'b111110, 8, 0, 'h110);
    prog[13] = encImm(6'b111010, 9, 0, 'h100);
    prog[14] = encImm(6'b111110, 9, 0, 'h114);
    prog[15] = encImm(6'b101110, 0, 0, 12);   // BRI to word 18
    prog[16] = encImm(6'b111110, 1, 0, 'h118);
    prog[17] = encImm(6'b111110, 2, 0, 'h11C);
    prog[18] = encImm(6'b101111, 0, 0, 12);   // BEQI taken to word 21
    prog[19] = encImm(6'b111110, 1, 0, 'h118);
    prog[20] = encImm(6'b111110, 2, 0, 'h11C);
    prog[21] = encImm(6'b101111, 0, 1, 12);   // BEQI not taken
    prog[22] = encImm(6'b111110, 1, 0, 'h120);
    prog[23] = encImm(6'b001000, 0, 1, 7);    // Write to r0
    prog[24] = encImm(6'b111110, 0, 0, 'h124);
    prog[25] = encImm(6'b111110, 3, 2, 'h12B);
    prog[26] = encImm(6'b101110, 0, 0, 0);    // Self-branch ends the program
  endtask

  // Instruction-level model, fills the expected store queue
  task automatic runReference();
    logic [31:0] r [32];
    logic [31:0] mem [256];
    logic [31:0] pc;
    logic [31:0] w;
    logic [31:0] imm;
    logic [31:0] addr;
    int          rd;
    int          ra;
    int          rb;
    pc = `AEXM_RESET_VECTOR;
    for (int i = 0; i < 32; i++) begin
      r[i] = '0;
    end
    for (int i = 0; i < 256; i++) begin
      mem[i] = memFill(i);
    end
    for (int step = 0; step < 1000; step++) begin
      w    = prog[pc[7:2]];
      rd   = w[25:21];
      ra   = w[20:16];
      rb   = w[15:11];
      imm  = {{16{w[15]}}, w[15:0]};
      addr = r[ra] + imm;
      if (w[31:26] == 6'b101110 && imm == 0) begin
        break;
      end
      pc = pc + 4;
      case (w[31:26])
        6'b000000: r[rd] = r[ra] + r[rb];
        6'b100001: r[rd] = r[ra] & r[rb];
        6'b100000: r[rd] = r[ra] | r[rb];
        6'b100010: r[rd] = r[ra] ^ r[rb];
        6'b001000: r[rd] = r[ra] + imm;
        6'b111010: r[rd] = mem[addr[9:2]];
        6'b111110: begin
          mem[addr[9:2]] = r[rd];
          storeQ.push_back('{addr: addr, data: r[rd]});
        end
        6'b101110: pc = pc - 4 + imm;
        6'b101111: pc = (r[ra] == 0) ? pc - 4 + imm : pc;
        default: ;
      endcase
      r[0] = '0;
    end
  endtask

  initial begin
    sys_clk = 1'b0;
    forever #4 sys_clk = ~sys_clk;
  end

  initial begin
    buildProgram();
    for (int i = 0; i < 64; i++) begin
      cacheModel_inst.rom[i] = prog[i];
    end
    runReference();
    repeat (3) @(posedge sys_clk);
    reset_i <= 1'b0;
    do begin
      @(posedge sys_clk);
    end while (reset_i || storeQ.size() != 0);
    repeat (20) @(posedge sys_clk);  // Catches duplicate stores after the last one
    $display("*** PASSED ***");
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    stopOnError("Watchdog expired before all expected stores were seen");
  end

  // Retire the head of the queue on each observed store
  always @(posedge sys_clk) begin
    if (!reset_i && dcacheReq.we && storeQ.size() > 0) begin
      void'(storeQ.pop_front());
    end
    expValid <= storeQ.size() > 0;
    expHead  <= (storeQ.size() > 0) ? storeQ[0] : '0;
  end

  assert property (@(posedge sys_clk) $fell(reset_i) |->
    icacheReq.enable && icacheReq.precycleAddr == `AEXM_RESET_VECTOR &&
    !dcacheReq.enable && !dcacheReq.we)
    else stopOnError("First cycle after reset does not fetch the reset vector cleanly");

  assert property (@(posedge sys_clk) disable iff (reset_i) dcacheReq.we |-> expValid)
    else stopOnError("Store seen when none was expected");

  assert property (@(posedge sys_clk) disable iff (reset_i)
    dcacheReq.we && expValid |-> dcacheReq.precycleAddr == expHead.addr)
    else stopOnError($sformatf("FAIL %0t dcacheReq_o.precycleAddr expected %h got %h",
      $time, $sampled(expHead.addr), $sampled(dcacheReq.precycleAddr)));

  assert property (@(posedge sys_clk) disable iff (reset_i)
    dcacheReq.we && expValid |-> dcacheReq.wrData == expHead.data)
    else stopOnError($sformatf("FAIL %0t dcacheReq_o.wrData expected %h got %h",
      $time, $sampled(expHead.data), $sampled(dcacheReq.wrData)));

endmodule

//--- project.f
+incdir+include
hdl/aexmIsaPkg.sv
hdl/aexmBusPkg.sv
hdl/aexmEnable.sv
hdl/aexmFetch.sv
hdl/aexmIbuf.sv
hdl/aexmRegf.sv
hdl/aexmExec.sv
hdl/aexmCore.sv
test/aexmCacheModel.sv
test/aexmCoreTb.sv

//--- Bender.yml
package:
  name: aexm_core

sources:
  - include_dirs:
      - include
    files:
      - hdl/aexmIsaPkg.sv
      - hdl/aexmBusPkg.sv
      - hdl/aexmEnable.sv
      - hdl/aexmFetch.sv
      - hdl/aexmIbuf.sv
      - hdl/aexmRegf.sv
      - hdl/aexmExec.sv
      - hdl/aexmCore.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/aexmCacheModel.sv
      - test/aexmCoreTb.sv
